// ==== source/event_pkg.sv ====
package event_pkg;

    typedef logic [7:0]  byte_t;      // one serial data byte
    typedef logic [3:0]  seq_t;       // frame sequence number
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam int    CLKS_PER_BIT     = 4;
    localparam int    BITS_PER_FRAME   = 10;   // start, 8 data, stop
    localparam byte_t EVENT_CODE_RESET = 8'hAA;

    // register map
    localparam apb_addr_t REG_CTRL       = 8'h00;  // [0] block, [1] game_started
    localparam apb_addr_t REG_EVENT_CODE = 8'h04;
    localparam apb_addr_t REG_STATUS     = 8'h08;  // [0] busy, [15:8] frames sent
    localparam apb_addr_t REG_SOFT_START = 8'h0C;  // write 1 to bit 0

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic  send;
        byte_t data;
    } tx_req_t;

    typedef enum logic [1:0] {IDLE, BUILDING_PAYLOAD, SENDING_DATA} framer_state_t;

    typedef enum logic [1:0] {U_IDLE, U_START, U_DATA, U_STOP} uart_state_t;

endpackage

// ==== source/apb_event_regs.sv ====
module apb_event_regs
    import event_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  apb_req_t apb,
    input  logic     frame_busy,
    input  logic     frame_done,
    output apb_rsp_t apb_rsp,
    output logic     block,
    output logic     game_started,
    output byte_t    event_code,
    output logic     soft_start
);

    logic  wr_en;
    byte_t frames_sent;

    assign wr_en = apb.psel && apb.penable && apb.pwrite;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            block        <= 1'b0;
            game_started <= 1'b0;
            event_code   <= EVENT_CODE_RESET;
            soft_start   <= 1'b0;
            frames_sent  <= '0;
        end else begin
            soft_start <= 1'b0;   // single cycle pulse
            if (wr_en) begin
                case (apb.paddr)
                    REG_CTRL: begin
                        block        <= apb.pwdata[0];
                        game_started <= apb.pwdata[1];
                    end
                    REG_EVENT_CODE: event_code <= apb.pwdata[7:0];
                    REG_SOFT_START: soft_start <= apb.pwdata[0];
                    default: ;
                endcase
            end
            if (frame_done) begin
                frames_sent <= frames_sent + 8'd1;   // wraps at 256
            end
        end
    end

    // no wait states, no errors
    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = 1'b0;
        case (apb.paddr)
            REG_CTRL:       apb_rsp.prdata = {30'd0, game_started, block};
            REG_EVENT_CODE: apb_rsp.prdata = {24'd0, event_code};
            REG_STATUS:     apb_rsp.prdata = {16'd0, frames_sent, 7'd0, frame_busy};
            default:        apb_rsp.prdata = '0;   // soft start and unmapped
        endcase
    end

    // access phase must follow a setup phase
    a_apb_phase: assert property (
        @(posedge clk) disable iff (reset)
        apb.penable |-> apb.psel && $past(apb.psel)
    ) else $error("penable without a preceding psel setup phase");

endmodule

// ==== source/payload_builder.sv ====
module payload_builder
    import event_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  build_payload,
    input  logic  game_started,
    output byte_t payload,
    output logic  payload_ready
);

    seq_t seq;
    logic capture;

    // first cycle of a request only
    assign capture = build_payload && !payload_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            seq           <= '0;
            payload_ready <= 1'b0;
        end else begin
            payload_ready <= capture;
            if (capture) begin
                seq <= seq + 4'd1;   // wraps 15 -> 0
            end
        end
    end

    // snapshot so a mid-frame flag change can't alter the byte in flight
    always_ff @(posedge clk) begin
        if (capture) begin
            payload <= {seq, 3'b000, game_started};
        end
    end

endmodule

// ==== source/event_framer.sv ====
module event_framer
    import event_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    start,
    input  logic    block,
    input  byte_t   event_code,
    input  byte_t   payload,
    input  logic    payload_ready,
    input  logic    tx_busy,
    input  logic    data_sent,
    output logic    build_payload,
    output tx_req_t tx,
    output logic    frame_busy,
    output logic    frame_done
);

    framer_state_t state;
    logic [1:0]    byte_index;   // 0 code, 1 payload, 2 all issued

    assign build_payload = (state == BUILDING_PAYLOAD);
    assign frame_busy    = (state != IDLE);
    assign frame_done    = (state == SENDING_DATA) && (byte_index == 2'd2) && data_sent;

    always_comb begin
        tx.send = (state == SENDING_DATA) && !tx_busy && (byte_index != 2'd2);
        tx.data = (byte_index == 2'd0) ? event_code : payload;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= IDLE;
            byte_index <= 2'd0;
        end else begin
            case (state)
                IDLE: begin
                    byte_index <= 2'd0;
                    if (start && !block) begin   // blocked starts are lost
                        state <= BUILDING_PAYLOAD;
                    end
                end

                BUILDING_PAYLOAD: begin
                    if (payload_ready) begin
                        state <= SENDING_DATA;
                    end
                end

                SENDING_DATA: begin
                    if (tx.send) begin
                        byte_index <= byte_index + 2'd1;
                    end
                    if (frame_done) begin
                        state <= IDLE;   // last stop bit finished
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

    // every send must be taken by an idle UART
    a_send_accepted: assert property (
        @(posedge clk) disable iff (reset)
        tx.send |-> (state == SENDING_DATA && !tx_busy) ##1 tx_busy
    ) else $error("send issued outside SENDING_DATA or not accepted by the UART");

endmodule

// ==== source/uart_tx.sv ====
module uart_tx
    import event_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  tx_req_t tx,
    output logic    txd,
    output logic    tx_busy,
    output logic    data_sent
);

    uart_state_t                       state;
    logic [$clog2(CLKS_PER_BIT)-1:0]   bit_cnt;
    logic [2:0]                        bit_idx;
    byte_t                             shift;
    logic                              bit_end;

    assign bit_end = (bit_cnt == CLKS_PER_BIT - 1);
    assign tx_busy = (state != U_IDLE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= U_IDLE;
            bit_cnt   <= '0;
            bit_idx   <= '0;
            txd       <= 1'b1;   // line idles high
            data_sent <= 1'b0;
        end else begin
            data_sent <= 1'b0;
            if (state == U_IDLE || bit_end) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end

            case (state)
                U_IDLE: begin
                    if (tx.send) begin
                        state <= U_START;
                        txd   <= 1'b0;
                    end
                end

                U_START: begin
                    if (bit_end) begin
                        state   <= U_DATA;
                        bit_idx <= '0;
                        txd     <= shift[0];   // lsb first
                    end
                end

                U_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'(BITS_PER_FRAME - 3)) begin   // last data bit
                            state <= U_STOP;
                            txd   <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                            txd     <= shift[1];   // shift moves on this same edge
                        end
                    end
                end

                U_STOP: begin
                    if (bit_end) begin
                        state     <= U_IDLE;
                        data_sent <= 1'b1;
                    end
                end

                default: state <= U_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == U_IDLE && tx.send) begin
            shift <= tx.data;
        end else if (state == U_DATA && bit_end) begin
            shift <= shift >> 1;
        end
    end

    // busy lasts one whole frame and only drops together with the byte-done pulse
    a_busy_fall: assert property (
        @(posedge clk) disable iff (reset)
        $fell(tx_busy) |-> data_sent
            && $past(tx_busy, BITS_PER_FRAME * CLKS_PER_BIT)
            && !$past(tx_busy, BITS_PER_FRAME * CLKS_PER_BIT + 1)
    ) else $error("tx_busy fell without data_sent or after the wrong number of cycles");

endmodule

// ==== source/game_event_top.sv ====
module game_event_top
    import event_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  apb_req_t apb,
    input  logic     start,
    output apb_rsp_t apb_rsp,
    output logic     txd
);

    logic    block;
    logic    game_started;
    byte_t   event_code;
    logic    soft_start;
    logic    start_any;
    logic    build_payload;
    logic    payload_ready;
    byte_t   payload;
    tx_req_t tx;
    logic    tx_busy;
    logic    data_sent;
    logic    frame_busy;
    logic    frame_done;

    assign start_any = start | soft_start;   // pin or host write

    apb_event_regs u_regs (
        .clk          (clk),
        .reset        (reset),
        .apb          (apb),
        .frame_busy   (frame_busy),
        .frame_done   (frame_done),
        .apb_rsp      (apb_rsp),
        .block        (block),
        .game_started (game_started),
        .event_code   (event_code),
        .soft_start   (soft_start)
    );

    payload_builder u_builder (
        .clk           (clk),
        .reset         (reset),
        .build_payload (build_payload),
        .game_started  (game_started),
        .payload       (payload),
        .payload_ready (payload_ready)
    );

    event_framer u_framer (
        .clk           (clk),
        .reset         (reset),
        .start         (start_any),
        .block         (block),
        .event_code    (event_code),
        .payload       (payload),
        .payload_ready (payload_ready),
        .tx_busy       (tx_busy),
        .data_sent     (data_sent),
        .build_payload (build_payload),
        .tx            (tx),
        .frame_busy    (frame_busy),
        .frame_done    (frame_done)
    );

    uart_tx u_uart (
        .clk       (clk),
        .reset     (reset),
        .tx        (tx),
        .txd       (txd),
        .tx_busy   (tx_busy),
        .data_sent (data_sent)
    );

endmodule

// ==== test/uart_frame_checker.sv ====
module uart_frame_checker
    import event_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        txd,
    input  apb_req_t    apb,
    input  apb_rsp_t    apb_rsp,
    input  logic        exp_frame_valid,
    input  logic [15:0] exp_frame,
    input  logic        exp_read_valid,
    input  apb_data_t   exp_read,
    output int          frames_rx
);

    logic [15:0] frame_q[$];
    int          pass_count = 0;
    int          fail_count = 0;
    byte_t       first_byte;
    byte_t       rx_byte;
    logic        have_first = 1'b0;
    logic        stop_ok;

    always @(posedge clk) begin
        if (exp_frame_valid) begin
            frame_q.push_back(exp_frame);
        end
        // every access completes at once without an error
        if (apb.psel && apb.penable &&
            (apb_rsp.pready !== 1'b1 || apb_rsp.pslverr !== 1'b0)) begin
            fail_count++;
            $display("Fail at %0t: access to 0x%02h gave pready %b pslverr %b, expected 1 0",
                     $time, apb.paddr, apb_rsp.pready, apb_rsp.pslverr);
        end
        if (apb.psel && apb.penable && !apb.pwrite && exp_read_valid) begin
            if (apb_rsp.prdata === exp_read) begin
                pass_count++;
                $display("Pass read of 0x%02h returned 0x%08h", apb.paddr, exp_read);
            end else begin
                fail_count++;
                $display("Fail at %0t: read of 0x%02h returned 0x%08h, expected 0x%08h",
                         $time, apb.paddr, apb_rsp.prdata, exp_read);
            end
        end
    end

    // called on the first sample of a start bit, samples each bit mid way
    task automatic receive_byte(output byte_t data, output logic ok);
        repeat (CLKS_PER_BIT / 2 - 1) @(posedge clk);
        ok = (txd === 1'b0);
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(posedge clk);
            data[i] = txd;   // lsb first
        end
        repeat (CLKS_PER_BIT) @(posedge clk);
        ok = ok && (txd === 1'b1);
    endtask

    task automatic check_frame(input logic [15:0] got);
        logic [15:0] want;
        if (frame_q.size() == 0) begin
            fail_count++;
            $display("an unexpected frame %02h %02h arrived on txd at time %0t",
                     got[15:8], got[7:0], $time);
        end else begin
            want = frame_q.pop_front();
            if (got === want) begin
                pass_count++;
                $display("Pass frame %02h %02h", got[15:8], got[7:0]);
            end else begin
                fail_count++;
                $display("Fail at %0t: frame %02h %02h, expected %02h %02h", $time,
                         got[15:8], got[7:0], want[15:8], want[7:0]);
            end
        end
    endtask

    initial begin
        frames_rx = 0;
        forever begin
            do begin
                @(posedge clk);
            end while (reset || txd !== 1'b0);
            receive_byte(rx_byte, stop_ok);
            if (!stop_ok) begin
                fail_count++;
                $display("Fail at %0t: bad start or stop bit around byte %02h", $time, rx_byte);
            end
            if (!have_first) begin
                first_byte = rx_byte;
                have_first = 1'b1;
            end else begin
                have_first = 1'b0;
                check_frame({first_byte, rx_byte});
                frames_rx <= frames_rx + 1;
            end
        end
    end

    task automatic summarize(output int fails);
        if (frame_q.size() != 0) begin
            $display("%0d expected frames never arrived on txd", frame_q.size());
            fail_count += frame_q.size();
        end
        if (have_first) begin
            $display("a single byte arrived without the second byte of its frame");
            fail_count++;
        end
        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        fails = fail_count;
    endtask

endmodule

// ==== test/tb_game_event.sv ====
module tb_game_event
    import event_pkg::*;
();

    logic        clk;
    logic        reset;
    apb_req_t    apb;
    apb_rsp_t    apb_rsp;
    logic        start;
    logic        txd;

    logic        exp_frame_valid;
    logic [15:0] exp_frame;
    logic        exp_read_valid;
    apb_data_t   exp_read;
    int          frames_rx;

    byte         ops[$];
    apb_data_t   arg_a[$];
    apb_data_t   arg_b[$];
    logic [31:0] lfsr = 32'h0a2b_09bd;
    int          frames_expected = 0;
    int          cycles = 0;
    int          limit = 0;
    int          fails;
    logic        loaded;
    apb_data_t   rd;

    game_event_top u_dut (
        .clk     (clk),
        .reset   (reset),
        .apb     (apb),
        .start   (start),
        .apb_rsp (apb_rsp),
        .txd     (txd)
    );

    uart_frame_checker u_chk (
        .clk             (clk),
        .reset           (reset),
        .txd             (txd),
        .apb             (apb),
        .apb_rsp         (apb_rsp),
        .exp_frame_valid (exp_frame_valid),
        .exp_frame       (exp_frame),
        .exp_read_valid  (exp_read_valid),
        .exp_read        (exp_read),
        .frames_rx       (frames_rx)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic load_cases(output logic ok);
        int        fd;
        int        n;
        string     line;
        byte       op;
        apb_data_t a;
        apb_data_t b;
        ok = 1'b0;
        fd = $fopen("test/event_cases.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0) begin
                    op = line.getc(0);
                    if (op == "W" || op == "R" || op == "S" || op == "F" || op == "G") begin
                        a = '0;
                        b = '0;
                        n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
                        ops.push_back(op);
                        arg_a.push_back(a);
                        arg_b.push_back(b);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic insert_gap();
        int n;
        n = 0;
        repeat (2) begin
            lfsr = lfsr_next(lfsr);
            n = (n << 1) | lfsr[0];
        end
        repeat (n) @(posedge clk);
    endtask

    task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
        @(posedge clk);
        apb.psel   <= 1'b1;   // setup phase
        apb.pwrite <= 1'b1;
        apb.paddr  <= addr;
        apb.pwdata <= data;
        @(posedge clk);
        apb.penable <= 1'b1;
        @(posedge clk);
        apb <= '0;
    endtask

    task automatic read_reg(input apb_addr_t addr, input logic check,
                            input apb_data_t expected, output apb_data_t data);
        @(posedge clk);
        apb.psel   <= 1'b1;
        apb.pwrite <= 1'b0;
        apb.paddr  <= addr;
        @(posedge clk);
        apb.penable    <= 1'b1;
        exp_read_valid <= check;
        exp_read       <= expected;
        @(posedge clk);
        data = apb_rsp.prdata;   // access phase value
        apb            <= '0;
        exp_read_valid <= 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic expect_frame(input byte_t code, input byte_t payload);
        apb_data_t status;
        @(posedge clk);
        exp_frame_valid <= 1'b1;
        exp_frame       <= {code, payload};
        frames_expected++;
        @(posedge clk);
        exp_frame_valid <= 1'b0;
        while (frames_rx < frames_expected) @(posedge clk);
        // framer must be back in IDLE before the next start
        do begin
            read_reg(REG_STATUS, 1'b0, '0, status);
        end while (status[0]);
    endtask

    initial begin
        reset           = 1'b1;
        apb             = '0;
        start           = 1'b0;
        exp_frame_valid = 1'b0;
        exp_frame       = '0;
        exp_read_valid  = 1'b0;
        exp_read        = '0;
        load_cases(loaded);
        if (!loaded) begin
            $display("could not open test/event_cases.txt");
            $display("Regression failed");
        end else begin
            limit = 200 * ops.size() + 100;
            repeat (2) @(posedge clk);
            reset <= 1'b0;
            foreach (ops[i]) begin
                insert_gap();
                case (ops[i])
                    "W": write_reg(arg_a[i][7:0], arg_b[i]);
                    "R": read_reg(arg_a[i][7:0], 1'b1, arg_b[i], rd);
                    "S": pulse_start();
                    "F": expect_frame(arg_a[i][7:0], arg_b[i][7:0]);
                    "G": repeat (arg_a[i]) @(posedge clk);
                    default: ;
                endcase
            end
            u_chk.summarize(fails);
            if (fails == 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
        end
        $finish;
    end

    initial begin
        wait (limit != 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles with %0d frames still expected",
                 cycles, frames_expected - frames_rx);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== test/event_cases.txt ====
# op a b, all values hex
# W addr data | R addr expected | S start pulse | F code payload | G cycles
R 08 0
R 04 aa
G 20
S
F aa 00
W 00 2
S
F aa 11
W 04 5c
W 0c 1
F 5c 21
W 00 3
S
G 10
W 0c 1
G 60
R 08 300
W 00 2
S
F 5c 31
S
G 10
S
G 10
S
F 5c 41
R 08 500
S
F 5c 51
S
F 5c 61
S
F 5c 71
S
F 5c 81
S
F 5c 91
S
F 5c a1
S
F 5c b1
S
F 5c c1
S
F 5c d1
S
F 5c e1
S
F 5c f1
S
F 5c 01
S
F 5c 11
S
F 5c 21
S
F 5c 31
S
F 5c 41
S
F 5c 51
R 08 1600
R 00 2
G 60

// ==== vlog.f ====
source/event_pkg.sv
source/apb_event_regs.sv
source/payload_builder.sv
source/event_framer.sv
source/uart_tx.sv
source/game_event_top.sv
test/uart_frame_checker.sv
test/tb_game_event.sv
